// File: verilog/mmio_pkg.sv
// ==================================================
// MMIO bridge shared types
// TLX opcodes, response codes, widths and the
// structs passed between the bridge blocks
// ==================================================
package mmio_pkg;

   // ==================================================
   // Plain widths
   // ==================================================
   typedef logic [7:0]   tl_opcode_t;      // TLX opcode
   typedef logic [3:0]   resp_code_t;      // TLX response code
   typedef logic [15:0]  capptag_t;        // Host command tag
   typedef logic [63:0]  pa_t;             // Physical address
   typedef logic [31:0]  mmio_addr_t;      // Low part of pa
   typedef logic [63:0]  mmio_data_t;      // One MMIO word
   typedef logic [511:0] line_t;           // Full TLX data flit
   typedef logic [2:0]   lane_t;           // 64-bit lane, pa[5:3]
   typedef logic [3:0]   resp_credit_t;
   typedef logic [5:0]   data_credit_t;

   // Host to AFU opcodes, partial memory only
   localparam tl_opcode_t OPC_PR_RD_MEM = 8'h28;
   localparam tl_opcode_t OPC_PR_WR_MEM = 8'h86;

   // AFU to host response opcodes
   localparam tl_opcode_t RESP_MEM_RD_RESPONSE = 8'h01;
   localparam tl_opcode_t RESP_MEM_RD_FAIL     = 8'h02;
   localparam tl_opcode_t RESP_MEM_WR_RESPONSE = 8'h04;
   localparam tl_opcode_t RESP_MEM_WR_FAIL     = 8'h05;

   // Response codes
   localparam resp_code_t CODE_NULL     = 4'h0;
   localparam resp_code_t CODE_DERROR   = 4'h8;   // Corrupt write data
   localparam resp_code_t CODE_BAD_ADDR = 4'hB;   // Outside BAR0 or misaligned
   localparam resp_code_t CODE_FAILED   = 4'hE;   // MMIO side gave up

   // Payload length codes
   localparam logic [2:0] PL_4B = 3'd2;
   localparam logic [2:0] PL_8B = 3'd3;

   typedef enum logic {FAULT_BAD_ADDR, FAULT_DATA_ERR} fault_e;

   typedef enum logic [1:0] {ST_IDLE, ST_STROBE, ST_WAIT} access_state_e;

   // ==================================================
   // Structs
   // ==================================================
   typedef struct packed {
      tl_opcode_t opcode;
      capptag_t   capptag;
      logic [2:0] pl;
      pa_t        pa;
   } tlx_cmd_t;

   typedef struct packed {
      logic       wr;     // Write when set, read otherwise
      logic       dw;     // 8-byte access
      mmio_addr_t addr;
      mmio_data_t data;
   } mmio_req_t;

   typedef struct packed {
      logic       failed;
      mmio_data_t data;
   } mmio_result_t;

   // Command context kept for the response side
   typedef struct packed {
      logic     wr;
      capptag_t capptag;
      lane_t    lane;
   } cmd_ctx_t;

   typedef struct packed {
      tl_opcode_t opcode;
      capptag_t   capptag;
      resp_code_t code;
   } tlx_resp_t;

endpackage

// File: verilog/tlx_cmd_decode.sv
// ==================================================
// TLX command decode
// Latches partial memory commands, checks BAR0 and
// alignment, picks the write lane, issues work
// ==================================================
`timescale 1ns/100ps

module tlx_cmd_decode import mmio_pkg::*; (
   input  logic      clk_tlx,
   input  logic      rst_n,
   input  pa_t       cfg_f1_mmio_bar0,
   input  pa_t       cfg_f1_mmio_bar0_mask,
   input  logic      tlx_afu_cmd_valid,
   input  tlx_cmd_t  tlx_afu_cmd,
   input  logic      tlx_afu_cmd_data_valid,
   input  logic      tlx_afu_cmd_data_bdi,
   input  line_t     tlx_afu_cmd_data_bus,
   output logic      afu_tlx_cmd_rd_req,
   output logic      access_go,
   output mmio_req_t access_req,
   output logic      fault_valid,
   output fault_e    fault,
   output cmd_ctx_t  cmd_ctx
);

   tlx_cmd_t   cmd_q;          // Held until next command
   logic       cmd_valid_q;
   logic       data_valid_q;
   logic       data_bdi_q;
   mmio_data_t data_q;         // Selected lane of the flit
   logic       cmd_wr;
   logic       cmd_rd;
   logic       cmd_dw;
   logic       in_bar0;
   logic       aligned;
   logic       granted;
   logic       cmd_fault;
   logic       data_fault;

   // ==================================================
   // Command and data capture
   // ==================================================
   always_ff @(posedge clk_tlx)
   begin
      if (tlx_afu_cmd_valid)
         cmd_q <= tlx_afu_cmd;
      if (tlx_afu_cmd_data_valid)
      begin
         data_q     <= tlx_afu_cmd_data_bus[cmd_q.pa[5:3]*64 +: 64];  // Lane by pa[5:3]
         data_bdi_q <= tlx_afu_cmd_data_bdi;
      end
   end

   // Valid strobes delayed one cycle to line up with the latched fields
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_valid_q        <= 1'b0;
         data_valid_q       <= 1'b0;
         afu_tlx_cmd_rd_req <= 1'b0;
      end
      else
      begin
         cmd_valid_q        <= tlx_afu_cmd_valid;
         data_valid_q       <= tlx_afu_cmd_data_valid;
         // Ask for the data flit straight away on a partial write
         afu_tlx_cmd_rd_req <= tlx_afu_cmd_valid && (tlx_afu_cmd.opcode == OPC_PR_WR_MEM);
      end
   end

   // ==================================================
   // Decode and checks
   // ==================================================
   assign cmd_wr = (cmd_q.opcode == OPC_PR_WR_MEM);
   assign cmd_rd = (cmd_q.opcode == OPC_PR_RD_MEM);
   assign cmd_dw = (cmd_q.pl == PL_8B);

   assign in_bar0 = ((cmd_q.pa & cfg_f1_mmio_bar0_mask) == cfg_f1_mmio_bar0);
   assign aligned = ((cmd_q.pl == PL_4B) && (cmd_q.pa[1:0] == 2'b00)) ||
                    ((cmd_q.pl == PL_8B) && (cmd_q.pa[2:0] == 3'b000));
   assign granted = in_bar0 && aligned;

   // Bad address reported at command time, even for a write
   assign cmd_fault  = cmd_valid_q && (cmd_rd || cmd_wr) && !granted;
   // Poisoned flit on an otherwise good write
   assign data_fault = data_valid_q && cmd_wr && granted && data_bdi_q;

   // Read goes at command time, write once clean data is in
   assign access_go = (cmd_valid_q && cmd_rd && granted) ||
                      (data_valid_q && cmd_wr && granted && !data_bdi_q);

   assign access_req.wr   = cmd_wr;
   assign access_req.dw   = cmd_dw;
   assign access_req.addr = cmd_q.pa[31:0];
   assign access_req.data = data_q;     // Don't care on reads

   assign fault_valid = cmd_fault || data_fault;
   assign fault       = data_fault ? FAULT_DATA_ERR : FAULT_BAD_ADDR;

   // Context for the response block
   assign cmd_ctx.wr      = cmd_wr;
   assign cmd_ctx.capptag = cmd_q.capptag;
   assign cmd_ctx.lane    = cmd_q.pa[5:3];

endmodule

// File: verilog/mmio_access_ctrl.sv
// ==================================================
// MMIO access control
// Issues one MMIO strobe per request and waits for
// done or failed from the MMIO side
// ==================================================
`timescale 1ns/100ps

module mmio_access_ctrl import mmio_pkg::*; (
   input  logic         clk_tlx,
   input  logic         rst_n,
   input  logic         access_go,
   input  mmio_req_t    access_req,
   output logic         mmio_wr,
   output logic         mmio_rd,
   output logic         mmio_dw,
   output mmio_addr_t   mmio_addr,
   output mmio_data_t   mmio_din,
   input  mmio_data_t   mmio_dout,
   input  logic         mmio_done,
   input  logic         mmio_failed,
   output logic         result_valid,
   output mmio_result_t result
);

   access_state_e state;
   mmio_req_t     req_q;       // Request held for the strobe cycle
   logic          strobe;
   logic          finish;

   assign strobe = (state == ST_STROBE);
   assign finish = (state == ST_WAIT) && (mmio_done || mmio_failed);

   // ==================================================
   // State machine
   // ==================================================
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
         state <= ST_IDLE;
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (access_go)
                  state <= ST_STROBE;
            end
            ST_STROBE:
               state <= ST_WAIT;        // Strobe lasts one cycle
            ST_WAIT:
            begin
               if (mmio_done || mmio_failed)
                  state <= ST_IDLE;
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_tlx)
   begin
      if ((state == ST_IDLE) && access_go)
         req_q <= access_req;
   end

   // MMIO side strobes
   assign mmio_wr   = strobe && req_q.wr;
   assign mmio_rd   = strobe && !req_q.wr;
   assign mmio_dw   = strobe && req_q.dw;
   assign mmio_addr = req_q.addr;
   assign mmio_din  = req_q.data;

   // ==================================================
   // Result capture
   // ==================================================
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
         result_valid <= 1'b0;
      else
         result_valid <= finish;
   end

   always_ff @(posedge clk_tlx)
   begin
      if (finish)
         result.failed <= mmio_failed;   // Failed wins over done
      if (finish && mmio_done)
         result.data <= mmio_dout;
   end

endmodule

// File: verilog/tlx_resp_gen.sv
// ==================================================
// TLX response generator
// Builds opcode, code and lane-placed read data and
// holds MMIO results until credit is available
// ==================================================
`timescale 1ns/100ps

module tlx_resp_gen import mmio_pkg::*; (
   input  logic         clk_tlx,
   input  logic         rst_n,
   input  logic         fault_valid,
   input  fault_e       fault,
   input  logic         result_valid,
   input  mmio_result_t result,
   input  cmd_ctx_t     cmd_ctx,
   input  logic         credit_ok,
   output logic         afu_tlx_resp_valid,
   output tlx_resp_t    afu_tlx_resp,
   output logic         afu_tlx_rdata_valid,
   output line_t        afu_tlx_rdata_bus
);

   mmio_result_t result_q;     // Held while pending
   logic         pending;
   logic         fire;
   tlx_resp_t    resp_nxt;
   line_t        rdata_nxt;

   // MMIO result goes out once both credit pools have room
   assign fire = pending && credit_ok;

   // ==================================================
   // Opcode and code selection
   // ==================================================
   always_comb
   begin
      resp_nxt.capptag = cmd_ctx.capptag;       // Echo host tag
      if (fault_valid)
      begin
         if (fault == FAULT_DATA_ERR)
         begin
            resp_nxt.opcode = RESP_MEM_WR_FAIL;   // Only writes carry data
            resp_nxt.code   = CODE_DERROR;
         end
         else
         begin
            resp_nxt.opcode = cmd_ctx.wr ? RESP_MEM_WR_FAIL : RESP_MEM_RD_FAIL;
            resp_nxt.code   = CODE_BAD_ADDR;
         end
      end
      else if (result_q.failed)
      begin
         resp_nxt.opcode = cmd_ctx.wr ? RESP_MEM_WR_FAIL : RESP_MEM_RD_FAIL;
         resp_nxt.code   = CODE_FAILED;
      end
      else
      begin
         resp_nxt.opcode = cmd_ctx.wr ? RESP_MEM_WR_RESPONSE : RESP_MEM_RD_RESPONSE;
         resp_nxt.code   = CODE_NULL;
      end
   end

   // Read word into its lane, rest zero
   always_comb
   begin
      rdata_nxt = '0;
      rdata_nxt[cmd_ctx.lane*64 +: 64] = result_q.data;
   end

   // ==================================================
   // Pending result and output registers
   // ==================================================
   always_ff @(posedge clk_tlx)
   begin
      if (result_valid)
         result_q <= result;
      if (fault_valid || fire)
         afu_tlx_resp <= resp_nxt;
      if (fire)
         afu_tlx_rdata_bus <= rdata_nxt;
   end

   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pending             <= 1'b0;
         afu_tlx_resp_valid  <= 1'b0;
         afu_tlx_rdata_valid <= 1'b0;
      end
      else
      begin
         if (result_valid)
            pending <= 1'b1;
         else if (fire)
            pending <= 1'b0;
         afu_tlx_resp_valid  <= fault_valid || fire;    // Faults skip the credit gate
         afu_tlx_rdata_valid <= fire && !cmd_ctx.wr && !result_q.failed;
      end
   end

endmodule

// File: verilog/tlx_resp_credit.sv
// ==================================================
// TLX response credits
// Tracks response and response-data credits, loaded
// from the host's initial values after reset
// ==================================================
`timescale 1ns/100ps

module tlx_resp_credit import mmio_pkg::*; (
   input  logic         clk_tlx,
   input  logic         rst_n,
   input  logic         tlx_afu_resp_credit,
   input  logic         tlx_afu_resp_data_credit,
   input  resp_credit_t tlx_afu_resp_initial_credit,
   input  data_credit_t tlx_afu_resp_data_initial_credit,
   input  logic         afu_tlx_resp_valid,
   input  logic         afu_tlx_rdata_valid,
   output logic         credit_ok
);

   resp_credit_t resp_cnt;
   data_credit_t data_cnt;
   logic         loaded;       // Initial values taken

   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         loaded    <= 1'b0;
         resp_cnt  <= '0;
         data_cnt  <= '0;
         credit_ok <= 1'b0;
      end
      else if (!loaded)
      begin
         // First cycle out of reset
         loaded   <= 1'b1;
         resp_cnt <= tlx_afu_resp_initial_credit;
         data_cnt <= tlx_afu_resp_data_initial_credit;
      end
      else
      begin
         case ({tlx_afu_resp_credit, afu_tlx_resp_valid})
            2'b10:   resp_cnt <= resp_cnt + 4'd1;   // Host returned one
            2'b01:   resp_cnt <= resp_cnt - 4'd1;   // One used
            default: resp_cnt <= resp_cnt;
         endcase
         case ({tlx_afu_resp_data_credit, afu_tlx_rdata_valid})
            2'b10:   data_cnt <= data_cnt + 6'd1;
            2'b01:   data_cnt <= data_cnt - 6'd1;
            default: data_cnt <= data_cnt;
         endcase
         // Both pools must have room
         credit_ok <= (resp_cnt != '0) && (data_cnt != '0);
      end
   end

endmodule

// File: verilog/opencapi_mmio_top.sv
// ==================================================
// OpenCAPI MMIO target bridge top level
// Single clock, one command in flight
// ==================================================
`timescale 1ns/100ps

module opencapi_mmio_top import mmio_pkg::*; (
   input  logic         clk_tlx,
   input  logic         rst_n,
   input  pa_t          cfg_f1_mmio_bar0,
   input  pa_t          cfg_f1_mmio_bar0_mask,
   input  logic         tlx_afu_cmd_valid,
   input  tlx_cmd_t     tlx_afu_cmd,
   input  logic         tlx_afu_cmd_data_valid,
   input  logic         tlx_afu_cmd_data_bdi,
   input  line_t        tlx_afu_cmd_data_bus,
   output logic         afu_tlx_cmd_rd_req,
   output logic         afu_tlx_cmd_credit,
   output logic         afu_tlx_resp_valid,
   output tlx_resp_t    afu_tlx_resp,
   output logic         afu_tlx_rdata_valid,
   output line_t        afu_tlx_rdata_bus,
   input  logic         tlx_afu_resp_credit,
   input  logic         tlx_afu_resp_data_credit,
   input  resp_credit_t tlx_afu_resp_initial_credit,
   input  data_credit_t tlx_afu_resp_data_initial_credit,
   output logic         mmio_wr,
   output logic         mmio_rd,
   output logic         mmio_dw,
   output mmio_addr_t   mmio_addr,
   output mmio_data_t   mmio_din,
   input  mmio_data_t   mmio_dout,
   input  logic         mmio_done,
   input  logic         mmio_failed
);

   logic         access_go;
   mmio_req_t    access_req;
   logic         fault_valid;
   fault_e       fault;
   cmd_ctx_t     cmd_ctx;
   logic         result_valid;
   mmio_result_t result;
   logic         credit_ok;

   // Command credit comes back with each response
   assign afu_tlx_cmd_credit = afu_tlx_resp_valid;

   tlx_cmd_decode u_decode (.*);

   mmio_access_ctrl u_access (.*);

   tlx_resp_gen u_resp (.*);

   tlx_resp_credit u_credit (.*);

endmodule

// File: tb/tb_mmio_assert.sv
// ==================================================
// MMIO bridge protocol assertions
// Bound to the top level, checks strobes, response
// data lanes, command credit and fault responses
// ==================================================
`timescale 1ns/100ps

module tb_mmio_assert import mmio_pkg::*; (
   input logic      clk_tlx,
   input logic      rst_n,
   input logic      mmio_wr,
   input logic      mmio_rd,
   input logic      fault_valid,          // Internal decode fault strobe
   input logic      afu_tlx_resp_valid,
   input tlx_resp_t afu_tlx_resp,
   input logic      afu_tlx_rdata_valid,
   input logic      afu_tlx_cmd_credit
);

   int fail_cnt = 0;     // Failed assertion count

   // ==================================================
   // MMIO side strobes
   // ==================================================
   strobe_exclusive: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      !(mmio_wr && mmio_rd))
   else
   begin
      $error("mmio_wr and mmio_rd high in the same cycle");
      fail_cnt++;
   end

   // One-cycle strobes only
   strobe_single: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      (mmio_wr || mmio_rd) |=> !(mmio_wr || mmio_rd))
   else
   begin
      $error("MMIO strobe held longer than one cycle");
      fail_cnt++;
   end

   // ==================================================
   // TLX response side
   // ==================================================
   rdata_with_resp: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      afu_tlx_rdata_valid |->
         afu_tlx_resp_valid && (afu_tlx_resp.opcode == RESP_MEM_RD_RESPONSE))
   else
   begin
      $error("read data valid without a read response");
      fail_cnt++;
   end

   credit_with_resp: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      afu_tlx_cmd_credit == afu_tlx_resp_valid)
   else
   begin
      $error("command credit not aligned with response valid");
      fail_cnt++;
   end

   // Fault answered next cycle, MMIO side left alone
   fault_no_strobe: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      fault_valid |-> !(mmio_wr || mmio_rd) ##1
         (afu_tlx_resp_valid && !(mmio_wr || mmio_rd)))
   else
   begin
      $error("MMIO strobe or missing response after a fault");
      fail_cnt++;
   end

endmodule

bind opencapi_mmio_top tb_mmio_assert u_assert (.*);

// File: tb/tb_mmio.sv
// ==================================================
// MMIO bridge testbench
// TLX host and MMIO slave models, six directed tests
// ==================================================
`timescale 1ns/100ps

module tb_mmio import mmio_pkg::*; ();

   localparam pa_t BAR0 = 64'h0000_0041_2300_0000;
   localparam pa_t MASK = 64'hFFFF_FFFF_FF00_0000;     // 16 MB window

   logic         clk_tlx = 1'b0;
   logic         rst_n, tlx_afu_cmd_valid, tlx_afu_cmd_data_valid, tlx_afu_cmd_data_bdi;
   logic         afu_tlx_cmd_rd_req, afu_tlx_cmd_credit, afu_tlx_resp_valid;
   logic         afu_tlx_rdata_valid, mmio_wr, mmio_rd, mmio_dw;
   logic         tlx_afu_resp_credit = 1'b0;
   logic         tlx_afu_resp_data_credit = 1'b0;
   logic         mmio_done = 1'b0;
   logic         mmio_failed = 1'b0;
   pa_t          cfg_f1_mmio_bar0, cfg_f1_mmio_bar0_mask;
   tlx_cmd_t     tlx_afu_cmd;
   line_t        tlx_afu_cmd_data_bus, afu_tlx_rdata_bus;
   tlx_resp_t    afu_tlx_resp;
   resp_credit_t tlx_afu_resp_initial_credit;
   data_credit_t tlx_afu_resp_data_initial_credit;
   mmio_addr_t   mmio_addr;
   mmio_data_t   mmio_din;
   mmio_data_t   mmio_dout = '0;

   // Testbench state
   logic [31:0]  lfsr = 32'h0f503ec1;
   int           errors = 0, tests = 0, failed = 0, err_base = 0;
   int           strobes = 0, resps = 0, strobe_base, resp_base, slave_cnt = 0;
   int           slave_delay = 1;
   logic         slave_fail = 1'b0, kick_credit = 1'b0;
   logic         obs_wr, obs_dw, got_rdata_valid, got_cmd_credit;
   mmio_addr_t   obs_addr;
   mmio_data_t   obs_din, slave_data;
   tlx_resp_t    got_resp;
   line_t        got_rdata, flit;
   capptag_t     tag;
   tl_opcode_t   cmd_opc;
   logic [2:0]   cmd_pl;
   pa_t          cmd_pa;

   opencapi_mmio_top dut0 (.*);

   always #4 clk_tlx = ~clk_tlx;

   // Galois LFSR, one step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[62:0], lfsr[0]};
         lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return v;
   endfunction

   function automatic int total_errors();
      return errors + dut0.u_assert.fail_cnt;
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("MISMATCH %s got %h exp %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      assert (cond === 1'b1)
      else
      begin
         $display("%s", what);
         errors++;
      end
   endtask

   // ==================================================
   // MMIO slave, response monitor, credit return
   // ==================================================
   always @(posedge clk_tlx)
   begin
      mmio_done                <= 1'b0;
      mmio_failed              <= 1'b0;
      tlx_afu_resp_credit      <= kick_credit || afu_tlx_resp_valid;   // Host gives it straight back
      tlx_afu_resp_data_credit <= afu_tlx_rdata_valid;
      if (mmio_wr || mmio_rd)
      begin
         strobes++;
         obs_wr    = mmio_wr;
         obs_dw    = mmio_dw;
         obs_addr  = mmio_addr;
         obs_din   = mmio_din;
         slave_cnt = slave_delay;              // Answer after 1 to 8 cycles
      end
      else if (slave_cnt == 1)
      begin
         mmio_failed <= slave_fail;
         mmio_done   <= !slave_fail;
         mmio_dout   <= slave_data;
         slave_cnt = 0;
      end
      else if (slave_cnt > 1)
         slave_cnt--;
      if (afu_tlx_resp_valid)
      begin
         resps++;
         got_resp        = afu_tlx_resp;
         got_rdata       = afu_tlx_rdata_bus;
         got_rdata_valid = afu_tlx_rdata_valid;
         got_cmd_credit  = afu_tlx_cmd_credit;
      end
   end

   task automatic apply_reset(input resp_credit_t init_credit);
      @(posedge clk_tlx);
      rst_n                       <= 1'b0;
      tlx_afu_resp_initial_credit <= init_credit;
      repeat (16) @(posedge clk_tlx);
      rst_n <= 1'b1;
      repeat (4) @(posedge clk_tlx);
   endtask

   // ==================================================
   // TLX host, one command and its response
   // ==================================================
   task automatic send_cmd(input tl_opcode_t opc, input logic [2:0] pl, input pa_t pa,
                           input logic bdi, input logic fail, input logic hold);
      int wait_cyc;
      strobe_base = strobes;
      resp_base   = resps;
      cmd_opc     = opc;
      cmd_pl      = pl;
      cmd_pa      = pa;
      slave_fail  = fail;
      slave_delay = 1 + rand_bits(3);
      slave_data  = rand_bits(64);
      tag         = rand_bits(16);
      for (int i = 0; i < 16; i++)
         flit[i*32 +: 32] = rand_bits(32);
      @(posedge clk_tlx);
      tlx_afu_cmd_valid <= 1'b1;
      tlx_afu_cmd       <= '{opcode: opc, capptag: tag, pl: pl, pa: pa};
      @(posedge clk_tlx);
      tlx_afu_cmd_valid <= 1'b0;
      if (opc == OPC_PR_WR_MEM)
      begin
         @(negedge clk_tlx);
         expect_true(afu_tlx_cmd_rd_req, "no data read request after a write command");
         repeat (2) @(posedge clk_tlx);
         tlx_afu_cmd_data_valid <= 1'b1;
         tlx_afu_cmd_data_bus   <= flit;
         tlx_afu_cmd_data_bdi   <= bdi;
         @(posedge clk_tlx);
         tlx_afu_cmd_data_valid <= 1'b0;
      end
      if (hold)
      begin
         repeat (40) @(negedge clk_tlx);       // MMIO done long before this
         expect_true(resps == resp_base, "response sent with no response credit");
         @(posedge clk_tlx);
         kick_credit <= 1'b1;
         @(posedge clk_tlx);
         kick_credit <= 1'b0;
      end
      wait_cyc = 0;
      while (resps == resp_base && wait_cyc < 200)
      begin
         @(negedge clk_tlx);
         wait_cyc++;
      end
      expect_true(resps != resp_base, "no response within 200 cycles");
      repeat (8) @(negedge clk_tlx);          // Catch a second response
   endtask

   task automatic check_resp(input tl_opcode_t opc, input resp_code_t code, input int n_strobe);
      line_t exp_line;
      check_val("response count", resps - resp_base, 1);
      check_val("mmio strobe count", strobes - strobe_base, n_strobe);
      check_val("afu_tlx_resp.opcode", got_resp.opcode, opc);
      check_val("afu_tlx_resp.code", got_resp.code, code);
      check_val("afu_tlx_resp.capptag", got_resp.capptag, tag);
      check_val("afu_tlx_cmd_credit", got_cmd_credit, 1'b1);
      check_val("afu_tlx_rdata_valid", got_rdata_valid, opc == RESP_MEM_RD_RESPONSE);
      if (opc == RESP_MEM_RD_RESPONSE)
      begin
         exp_line = '0;
         exp_line[cmd_pa[5:3]*64 +: 64] = slave_data;     // Lane from pa[5:3]
         for (int i = 0; i < 8; i++)
            check_val($sformatf("afu_tlx_rdata_bus lane %0d", i), got_rdata[i*64 +: 64],
                      exp_line[i*64 +: 64]);
      end
      if (n_strobe != 0)
      begin
         check_val("mmio_wr", obs_wr, cmd_opc == OPC_PR_WR_MEM);
         check_val("mmio_dw", obs_dw, cmd_pl == PL_8B);
         check_val("mmio_addr", obs_addr, cmd_pa[31:0]);
         if (cmd_opc == OPC_PR_WR_MEM)
            check_val("mmio_din", obs_din, flit[cmd_pa[5:3]*64 +: 64]);
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (total_errors() == err_base)
         $display("test %0d %s passed", tests, name);
      else
      begin
         failed++;
         $display("test %0d %s failed", tests, name);
      end
      err_base = total_errors();
   endtask

   // ==================================================
   // Test sequence
   // ==================================================
   initial
   begin
      rst_n                            = 1'b0;
      cfg_f1_mmio_bar0                 = BAR0;
      cfg_f1_mmio_bar0_mask            = MASK;
      tlx_afu_cmd_valid                = 1'b0;
      tlx_afu_cmd                      = '0;
      tlx_afu_cmd_data_valid           = 1'b0;
      tlx_afu_cmd_data_bdi             = 1'b0;
      tlx_afu_cmd_data_bus             = '0;
      tlx_afu_resp_initial_credit      = 4'd4;
      tlx_afu_resp_data_initial_credit = 6'd8;
      apply_reset(4'd4);
      send_cmd(OPC_PR_WR_MEM, PL_8B, BAR0 | (rand_bits(24) & 64'hFF_FFF8), 0, 0, 0);
      check_resp(RESP_MEM_WR_RESPONSE, CODE_NULL, 1);
      finish_test("8-byte write");
      send_cmd(OPC_PR_RD_MEM, PL_4B, BAR0 | (rand_bits(24) & 64'hFF_FFFC), 0, 0, 0);
      check_resp(RESP_MEM_RD_RESPONSE, CODE_NULL, 1);
      finish_test("4-byte read");
      send_cmd(OPC_PR_RD_MEM, PL_8B, (BAR0 ^ 64'h1_0000_0000) | 64'h40, 0, 0, 0);
      check_resp(RESP_MEM_RD_FAIL, CODE_BAD_ADDR, 0);
      send_cmd(OPC_PR_WR_MEM, PL_8B, BAR0 | 64'h124, 0, 0, 0);   // Only 4-byte aligned
      check_resp(RESP_MEM_WR_FAIL, CODE_BAD_ADDR, 0);
      finish_test("bad address");
      send_cmd(OPC_PR_WR_MEM, PL_4B, BAR0 | (rand_bits(24) & 64'hFF_FFFC), 1, 0, 0);
      check_resp(RESP_MEM_WR_FAIL, CODE_DERROR, 0);
      finish_test("bad write data");
      send_cmd(OPC_PR_RD_MEM, PL_8B, BAR0 | (rand_bits(24) & 64'hFF_FFF8), 0, 1, 0);
      check_resp(RESP_MEM_RD_FAIL, CODE_FAILED, 1);
      send_cmd(OPC_PR_WR_MEM, PL_8B, BAR0 | (rand_bits(24) & 64'hFF_FFF8), 0, 1, 0);
      check_resp(RESP_MEM_WR_FAIL, CODE_FAILED, 1);
      finish_test("MMIO failed");
      apply_reset(4'd0);                        // No response credit at start
      send_cmd(OPC_PR_RD_MEM, PL_8B, BAR0 | (rand_bits(24) & 64'hFF_FFF8), 0, 0, 1);
      check_resp(RESP_MEM_RD_RESPONSE, CODE_NULL, 1);
      finish_test("credit hold");
      $display("tests %0d, failed %0d, errors %0d", tests, failed, total_errors());
      if (total_errors() == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // Six tests, 400 cycles each at most
   initial
   begin
      #(6 * 400 * 8);
      $display("Watchdog expired, run did not complete");
      $display("Errors found");
      $finish;
   end

endmodule

// File: build.f
verilog/mmio_pkg.sv
verilog/tlx_cmd_decode.sv
verilog/mmio_access_ctrl.sv
verilog/tlx_resp_gen.sv
verilog/tlx_resp_credit.sv
verilog/opencapi_mmio_top.sv
tb/tb_mmio_assert.sv
tb/tb_mmio.sv
